/* list.f */
+incdir+tests
src/rv_isa_pkg.sv
src/exec_pkg.sv
src/issue_fifo.sv
src/operand_sel.sv
src/alu.sv
src/div_unit.sv
src/exec_dispatch.sv
src/exec_top.sv
tests/tb_exec_top.sv

/* run.sh */
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_exec_top -f list.f

out=$(./obj_dir/Vtb_exec_top) || true
echo "$out"

if echo "$out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1

/* src/alu.sv */
`default_nettype none

module alu (
  input  rv_isa_pkg::alu_op_e alu_op_i,
  input  rv_isa_pkg::xlen_t   operand1_i,
  input  rv_isa_pkg::xlen_t   operand2_i,
  output rv_isa_pkg::xlen_t   result_o
);

  rv_isa_pkg::shamt_t shamt;
  logic               lt_signed;
  logic               lt_unsigned;
  logic signed [63:0] prod_ss;
  logic        [63:0] prod_uu;

  assign shamt       = operand2_i[4:0];
  assign lt_signed   = $signed(operand1_i) < $signed(operand2_i);
  assign lt_unsigned = operand1_i < operand2_i;

  // MULH needs both operands sign extended to the full product width.
  assign prod_ss = $signed({{32{operand1_i[31]}}, operand1_i}) *
                   $signed({{32{operand2_i[31]}}, operand2_i});
  assign prod_uu = {32'h0, operand1_i} * {32'h0, operand2_i};

  always_comb begin
    case (alu_op_i)
      rv_isa_pkg::ALU_OP_ADD: begin
        result_o = operand1_i + operand2_i;
      end
      rv_isa_pkg::ALU_OP_SUB: begin
        result_o = operand1_i - operand2_i;
      end
      rv_isa_pkg::ALU_OP_XOR: begin
        result_o = operand1_i ^ operand2_i;
      end
      rv_isa_pkg::ALU_OP_OR: begin
        result_o = operand1_i | operand2_i;
      end
      rv_isa_pkg::ALU_OP_AND: begin
        result_o = operand1_i & operand2_i;
      end
      rv_isa_pkg::ALU_OP_SLL: begin
        result_o = operand1_i << shamt;
      end
      rv_isa_pkg::ALU_OP_SRL: begin
        result_o = operand1_i >> shamt;
      end
      rv_isa_pkg::ALU_OP_SRA: begin
        result_o = rv_isa_pkg::xlen_t'($signed(operand1_i) >>> shamt);
      end
      rv_isa_pkg::ALU_OP_SLT: begin
        result_o = {31'h0, lt_signed};
      end
      rv_isa_pkg::ALU_OP_SLTU: begin
        result_o = {31'h0, lt_unsigned};
      end
      // Operand 1 is zero for LUI, so one adder serves both.
      rv_isa_pkg::ALU_OP_LUI,
      rv_isa_pkg::ALU_OP_AUIPC: begin
        result_o = operand1_i + operand2_i;
      end
      rv_isa_pkg::ALU_OP_JUMP: begin
        result_o = operand1_i + 32'd4;  // Link address.
      end
      rv_isa_pkg::ALU_OP_CSRR: begin
        result_o = operand1_i;
      end
      rv_isa_pkg::ALU_OP_MUL: begin
        result_o = prod_uu[31:0];
      end
      rv_isa_pkg::ALU_OP_MULH: begin
        result_o = prod_ss[63:32];
      end
      rv_isa_pkg::ALU_OP_MULHU: begin
        result_o = prod_uu[63:32];
      end
      default: begin
        result_o = '0;  // NOP and the divide ops.
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/div_unit.sv */
`default_nettype none

module div_unit (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                start_i,
  input  rv_isa_pkg::alu_op_e alu_op_i,
  input  rv_isa_pkg::xlen_t   dividend_i,
  input  rv_isa_pkg::xlen_t   divisor_i,
  output logic                done_o,
  output rv_isa_pkg::xlen_t   result_o
);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    FIX
  } div_state_e;

  div_state_e        state_q;
  logic [4:0]        cnt_q;
  rv_isa_pkg::xlen_t quo_q;
  rv_isa_pkg::xlen_t rem_q;
  rv_isa_pkg::xlen_t dvs_q;
  logic              q_neg_q;
  logic              r_neg_q;
  logic              is_rem_q;

  logic              is_signed;
  logic              a_neg;
  logic              b_neg;
  rv_isa_pkg::xlen_t a_mag;
  rv_isa_pkg::xlen_t b_mag;
  logic [32:0]       shifted;
  logic [32:0]       trial;

  assign is_signed = (alu_op_i == rv_isa_pkg::ALU_OP_DIV) || (alu_op_i == rv_isa_pkg::ALU_OP_REM);
  assign a_neg     = is_signed && dividend_i[31];
  assign b_neg     = is_signed && divisor_i[31];
  assign a_mag     = a_neg ? -dividend_i : dividend_i;
  assign b_mag     = b_neg ? -divisor_i : divisor_i;

  assign shifted = {rem_q, quo_q[31]};
  assign trial   = shifted - {1'b0, dvs_q};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: if (start_i) begin
          state_q <= RUN;
          cnt_q   <= 5'd31;
        end
        RUN: begin
          if (cnt_q == 5'd0) state_q <= FIX;
          cnt_q <= cnt_q - 1'b1;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // With a zero divisor the loop yields all ones and the dividend magnitude.
  // Clearing the quotient sign then gives the RISC-V values, and MIN / -1
  // comes out as MIN with a zero remainder without any special case.
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      quo_q    <= a_mag;
      rem_q    <= '0;
      dvs_q    <= b_mag;
      q_neg_q  <= (a_neg ^ b_neg) && (divisor_i != '0);
      r_neg_q  <= a_neg;
      is_rem_q <= (alu_op_i == rv_isa_pkg::ALU_OP_REM) || (alu_op_i == rv_isa_pkg::ALU_OP_REMU);
    end else if (state_q == RUN) begin
      if (!trial[32]) begin
        rem_q <= trial[31:0];
        quo_q <= {quo_q[30:0], 1'b1};
      end else begin
        rem_q <= shifted[31:0];
        quo_q <= {quo_q[30:0], 1'b0};
      end
    end
  end

  assign done_o   = (state_q == FIX);
  assign result_o = is_rem_q ? (r_neg_q ? -rem_q : rem_q) : (q_neg_q ? -quo_q : quo_q);

  a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    start_i |-> (state_q == IDLE));

endmodule

`default_nettype wire

/* src/exec_dispatch.sv */
`default_nettype none

module exec_dispatch #(
  parameter int RES_CREDITS = 2
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                head_valid_i,
  input  exec_pkg::exec_req_t head_req_i,
  output logic                pop_o,
  input  logic                res_credit_i,
  output logic                res_valid_o,
  output exec_pkg::exec_res_t res_o
);

  // One spare count so an excess credit return is visible.
  localparam int CNT_W = $clog2(RES_CREDITS + 2);

  typedef enum logic {
    IDLE,
    DIV_WAIT
  } disp_state_e;

  disp_state_e          state_q;
  logic [CNT_W-1:0]     credit_q;
  rv_isa_pkg::reg_idx_t div_rd_q;
  logic                 res_valid_q;
  exec_pkg::exec_res_t  res_q;

  rv_isa_pkg::xlen_t    operand1;
  rv_isa_pkg::xlen_t    operand2;
  rv_isa_pkg::xlen_t    alu_result;
  rv_isa_pkg::xlen_t    div_result;
  logic                 div_done;
  logic                 is_div;
  logic                 div_start;

  operand_sel operand_sel_i (
    .req_i      (head_req_i),
    .operand1_o (operand1),
    .operand2_o (operand2)
  );

  alu alu_i (
    .alu_op_i   (head_req_i.alu_op),
    .operand1_i (operand1),
    .operand2_i (operand2),
    .result_o   (alu_result)
  );

  div_unit div_unit_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .start_i    (div_start),
    .alu_op_i   (head_req_i.alu_op),
    .dividend_i (operand1),
    .divisor_i  (operand2),
    .done_o     (div_done),
    .result_o   (div_result)
  );

  assign is_div = (head_req_i.alu_op == rv_isa_pkg::ALU_OP_DIV)  ||
                  (head_req_i.alu_op == rv_isa_pkg::ALU_OP_DIVU) ||
                  (head_req_i.alu_op == rv_isa_pkg::ALU_OP_REM)  ||
                  (head_req_i.alu_op == rv_isa_pkg::ALU_OP_REMU);

  // The credit is taken at pop time, so every started op has a slot.
  assign pop_o     = head_valid_i && (state_q == IDLE) && (credit_q != '0);
  assign div_start = pop_o && is_div;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      credit_q    <= CNT_W'(RES_CREDITS);
      res_valid_q <= 1'b0;
    end else begin
      credit_q    <= credit_q + CNT_W'(res_credit_i) - CNT_W'(pop_o);
      res_valid_q <= (pop_o && !is_div) || div_done;
      case (state_q)
        IDLE:     if (div_start) state_q <= DIV_WAIT;
        DIV_WAIT: if (div_done) state_q <= IDLE;  // Nothing overtakes the divide.
        default:  state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (div_start) div_rd_q <= head_req_i.rd;
    if (div_done) begin
      res_q.rd   <= div_rd_q;
      res_q.data <= div_result;
    end else begin
      res_q.rd   <= head_req_i.rd;
      res_q.data <= alu_result;
    end
  end

  assign res_valid_o = res_valid_q;
  assign res_o       = res_q;

  a_credit_limit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credit_q <= CNT_W'(RES_CREDITS));

endmodule

`default_nettype wire

/* src/exec_pkg.sv */
`default_nettype none

// Records that move through the execute stage.
package exec_pkg;

  // One decoded micro-op as it leaves the issue unit.
  typedef struct packed {
    rv_isa_pkg::inst_type_e inst_type;
    rv_isa_pkg::alu_op_e    alu_op;
    rv_isa_pkg::pc_t        pc;
    rv_isa_pkg::xlen_t      imm;
    rv_isa_pkg::xlen_t      rdata1;
    rv_isa_pkg::xlen_t      rdata2;
    rv_isa_pkg::csr_data_t  csr_rdata;
    rv_isa_pkg::reg_idx_t   rd;
  } exec_req_t;

  // Write-back result, tagged with its destination register.
  typedef struct packed {
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::xlen_t    data;
  } exec_res_t;

endpackage

`default_nettype wire

/* src/exec_top.sv */
`default_nettype none

// Execute stage: issue buffer followed by the dispatch and compute logic.
module exec_top #(
  parameter int ISSUE_DEPTH = 4,
  parameter int RES_CREDITS = 2
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                issue_valid_i,
  input  exec_pkg::exec_req_t issue_req_i,
  output logic                issue_credit_o,
  input  logic                res_credit_i,
  output logic                res_valid_o,
  output exec_pkg::exec_res_t res_o
);

  logic                head_valid;
  exec_pkg::exec_req_t head_req;
  logic                pop;

  issue_fifo #(
    .ISSUE_DEPTH (ISSUE_DEPTH)
  ) issue_fifo_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .push_i         (issue_valid_i),
    .push_req_i     (issue_req_i),
    .pop_i          (pop),
    .head_valid_o   (head_valid),
    .head_req_o     (head_req),
    .issue_credit_o (issue_credit_o)
  );

  exec_dispatch #(
    .RES_CREDITS (RES_CREDITS)
  ) exec_dispatch_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .head_valid_i (head_valid),
    .head_req_i   (head_req),
    .pop_o        (pop),
    .res_credit_i (res_credit_i),
    .res_valid_o  (res_valid_o),
    .res_o        (res_o)
  );

endmodule

`default_nettype wire

/* src/issue_fifo.sv */
`default_nettype none

module issue_fifo #(
  parameter int ISSUE_DEPTH = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                push_i,
  input  exec_pkg::exec_req_t push_req_i,
  input  logic                pop_i,
  output logic                head_valid_o,
  output exec_pkg::exec_req_t head_req_o,
  output logic                issue_credit_o
);

  localparam int PTR_W = (ISSUE_DEPTH > 1) ? $clog2(ISSUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(ISSUE_DEPTH + 1);

  exec_pkg::exec_req_t mem_q [ISSUE_DEPTH];
  logic [PTR_W-1:0]    wr_ptr_q;
  logic [PTR_W-1:0]    rd_ptr_q;
  logic [CNT_W-1:0]    count_q;
  logic                do_pop;

  assign head_valid_o   = (count_q != '0);
  assign head_req_o     = mem_q[rd_ptr_q];
  assign do_pop         = pop_i && head_valid_o;
  assign issue_credit_o = do_pop;  // The freed slot goes straight back to the issuer.

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(ISSUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(ISSUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // An issuer that honours its credits never finds the buffer full.
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> (count_q != CNT_W'(ISSUE_DEPTH)));

  a_no_empty_pop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> head_valid_o);

endmodule

`default_nettype wire

/* src/operand_sel.sv */
`default_nettype none

module operand_sel (
  input  exec_pkg::exec_req_t req_i,
  output rv_isa_pkg::xlen_t   operand1_o,
  output rv_isa_pkg::xlen_t   operand2_o
);

  always_comb begin
    operand1_o = '0;
    operand2_o = '0;
    if (req_i.inst_type != rv_isa_pkg::INST_NOP && req_i.alu_op != rv_isa_pkg::ALU_OP_NOP) begin
      case (req_i.inst_type)
        rv_isa_pkg::INST_RR: begin
          operand1_o = req_i.rdata1;
          operand2_o = req_i.rdata2;
        end
        rv_isa_pkg::INST_RI: begin
          operand1_o = req_i.rdata1;
          operand2_o = req_i.imm;
        end
        rv_isa_pkg::INST_LUI: begin
          operand2_o = req_i.imm;  // Added to zero in the ALU.
        end
        rv_isa_pkg::INST_AUIPC: begin
          operand1_o = req_i.pc;
          operand2_o = req_i.imm;
        end
        // Jumps only need the pc, the ALU adds the link offset itself.
        rv_isa_pkg::INST_JAL,
        rv_isa_pkg::INST_JALR: begin
          operand1_o = req_i.pc;
        end
        rv_isa_pkg::INST_CSRR: begin
          operand1_o = req_i.csr_rdata;
        end
        default: begin
          operand1_o = '0;
          operand2_o = '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/rv_isa_pkg.sv */
`default_nettype none

// Widths and encodings shared by every block that handles RV32IM data.
package rv_isa_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;      // Integer register word.
  typedef logic [31:0]     pc_t;        // Instruction address.
  typedef logic [31:0]     csr_data_t;
  typedef logic [4:0]      reg_idx_t;   // Destination register number.
  typedef logic [4:0]      shamt_t;     // Shift amount.

  // Selects where the two ALU operands come from.
  typedef enum logic [2:0] {
    INST_NOP,
    INST_RR,
    INST_RI,
    INST_LUI,
    INST_AUIPC,
    INST_JAL,
    INST_JALR,
    INST_CSRR
  } inst_type_e;

  typedef enum logic [4:0] {
    ALU_OP_NOP,
    ALU_OP_ADD,
    ALU_OP_SUB,
    ALU_OP_XOR,
    ALU_OP_OR,
    ALU_OP_AND,
    ALU_OP_SLL,
    ALU_OP_SRL,
    ALU_OP_SRA,
    ALU_OP_SLT,
    ALU_OP_SLTU,
    ALU_OP_LUI,
    ALU_OP_AUIPC,
    ALU_OP_JUMP,
    ALU_OP_CSRR,
    ALU_OP_MUL,
    ALU_OP_MULH,
    ALU_OP_MULHU,
    ALU_OP_DIV,   // The last four are handled by the divider.
    ALU_OP_DIVU,
    ALU_OP_REM,
    ALU_OP_REMU
  } alu_op_e;

endpackage

`default_nettype wire

/* tests/exec_model.svh */
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Value that RV32IM defines for an integer, multiply or divide op on two operands.
function automatic rv_isa_pkg::xlen_t model_compute(rv_isa_pkg::alu_op_e op,
                                                   rv_isa_pkg::xlen_t a,
                                                   rv_isa_pkg::xlen_t b);
  logic signed [31:0] sa;
  logic signed [31:0] sb;
  logic signed [31:0] sq;
  logic signed [31:0] sr;
  logic signed [63:0] ps;
  logic        [63:0] pu;
  logic               overflow;
  sa       = a;
  sb       = b;
  ps       = sa * sb;
  pu       = {32'h0, a} * {32'h0, b};
  overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
  // Signed quotient and remainder for the cases the ISA leaves to plain division.
  sq       = '0;
  sr       = '0;
  if (b != '0 && !overflow) begin
    sq = sa / sb;
    sr = sa % sb;
  end
  case (op)
    rv_isa_pkg::ALU_OP_ADD:   return a + b;
    rv_isa_pkg::ALU_OP_SUB:   return a - b;
    rv_isa_pkg::ALU_OP_XOR:   return a ^ b;
    rv_isa_pkg::ALU_OP_OR:    return a | b;
    rv_isa_pkg::ALU_OP_AND:   return a & b;
    rv_isa_pkg::ALU_OP_SLL:   return a << b[4:0];
    rv_isa_pkg::ALU_OP_SRL:   return a >> b[4:0];
    rv_isa_pkg::ALU_OP_SRA:   return sa >>> b[4:0];
    rv_isa_pkg::ALU_OP_SLT:   return (sa < sb) ? 32'd1 : 32'd0;
    rv_isa_pkg::ALU_OP_SLTU:  return (a < b) ? 32'd1 : 32'd0;
    rv_isa_pkg::ALU_OP_MUL:   return pu[31:0];
    rv_isa_pkg::ALU_OP_MULH:  return ps[63:32];
    rv_isa_pkg::ALU_OP_MULHU: return pu[63:32];
    // Division by zero and the signed overflow case follow the ISA, no trap.
    rv_isa_pkg::ALU_OP_DIV:   return (b == '0) ? '1 : (overflow ? a : sq);
    rv_isa_pkg::ALU_OP_DIVU:  return (b == '0) ? '1 : a / b;
    rv_isa_pkg::ALU_OP_REM:   return (b == '0) ? a : (overflow ? '0 : sr);
    rv_isa_pkg::ALU_OP_REMU:  return (b == '0) ? a : a % b;
    default:                  return '0;
  endcase
endfunction

// Write-back record that a micro-op must produce.
function automatic exec_pkg::exec_res_t expected_result(exec_pkg::exec_req_t req);
  exec_pkg::exec_res_t res;
  res.rd   = req.rd;
  res.data = '0;
  if (req.inst_type != rv_isa_pkg::INST_NOP && req.alu_op != rv_isa_pkg::ALU_OP_NOP) begin
    case (req.inst_type)
      rv_isa_pkg::INST_RR:    res.data = model_compute(req.alu_op, req.rdata1, req.rdata2);
      rv_isa_pkg::INST_RI:    res.data = model_compute(req.alu_op, req.rdata1, req.imm);
      rv_isa_pkg::INST_LUI:   res.data = req.imm;
      rv_isa_pkg::INST_AUIPC: res.data = req.pc + req.imm;
      rv_isa_pkg::INST_JAL,
      rv_isa_pkg::INST_JALR:  res.data = req.pc + 32'd4;  // Link address.
      rv_isa_pkg::INST_CSRR:  res.data = req.csr_rdata;
      default:                res.data = '0;
    endcase
  end
  return res;
endfunction

`endif

/* tests/tb_exec_top.sv */
`default_nettype none

module tb_exec_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ISSUE_DEPTH = 4;
  localparam int RES_CREDITS = 2;
  localparam int N_ALU       = 40;
  localparam int N_MUL       = 12;
  localparam int N_DIV       = 16;  // Six corner cases, the rest random.
  localparam int N_SEL       = 16;
  localparam int N_ORDER     = 12;
  localparam int N_CREDIT    = 10;
  localparam int TOTAL_OPS   = N_ALU + N_MUL + N_DIV + N_SEL + N_ORDER + N_CREDIT;
  localparam int CYCLE_LIMIT = 2000 + 40 * TOTAL_OPS;

  logic                clk_i = 1'b0;
  logic                rst_n_i;
  logic                issue_valid_i;
  exec_pkg::exec_req_t issue_req_i;
  logic                issue_credit_o;
  logic                res_credit_i;
  logic                res_valid_o;
  exec_pkg::exec_res_t res_o;

  int                  seed = 32'h36464c3c;
  exec_pkg::exec_req_t pend_q[$];  // Ops still waiting for an issue credit.
  exec_pkg::exec_res_t exp_q[$];
  exec_pkg::exec_res_t exp_head;   // Result expected on the outputs this cycle.
  int                  issue_credits = ISSUE_DEPTH;
  int                  owed;       // Results whose slot has not gone back yet.
  logic                hold_credits;
  int                  issued;
  int                  results;
  int                  err_count;
  int                  tests_run;
  int                  tests_failed;
  int                  cycle_cnt;
  int                  errs_at_start;
  int                  ops_at_start;
  string               test_name;

  `include "exec_model.svh"

  exec_top #(
    .ISSUE_DEPTH (ISSUE_DEPTH),
    .RES_CREDITS (RES_CREDITS)
  ) exec_top_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .issue_valid_i  (issue_valid_i),
    .issue_req_i    (issue_req_i),
    .issue_credit_o (issue_credit_o),
    .res_credit_i   (res_credit_i),
    .res_valid_o    (res_valid_o),
    .res_o          (res_o)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, %0d results still missing.", cycle_cnt, exp_q.size());
      $display("STATUS: FAIL");
      $finish;
    end
  end

  a_result_match: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_o |-> (res_o == exp_head))
    else begin
      err_count++;
      $display("CHECK FAILED %s: expected rd %0d data %h, actual rd %0d data %h",
               test_name, exp_head.rd, exp_head.data, res_o.rd, res_o.data);
    end

  a_issuer_credits: assert property (@(posedge clk_i)
    (issue_credits >= 0) && (issue_credits <= ISSUE_DEPTH))
    else begin
      err_count++;
      $display("Issuer credit count left its range, now %0d.", issue_credits);
    end

  a_outstanding: assert property (@(posedge clk_i) owed <= RES_CREDITS)
    else begin
      err_count++;
      $display("More results outstanding than downstream slots, now %0d.", owed);
    end

  function automatic rv_isa_pkg::xlen_t rand_word();
    return $random(seed);
  endfunction

  function automatic rv_isa_pkg::alu_op_e op_from(rv_isa_pkg::alu_op_e first, int span);
    logic [4:0] offset;
    offset = 5'($unsigned($random(seed)) % span);
    return rv_isa_pkg::alu_op_e'(first + offset);
  endfunction

  function automatic exec_pkg::exec_req_t make_req(rv_isa_pkg::inst_type_e itype,
                                                   rv_isa_pkg::alu_op_e op);
    exec_pkg::exec_req_t r;
    r.inst_type = itype;
    r.alu_op    = op;
    r.pc        = rand_word() & 32'hffff_fffc;
    r.imm       = rand_word();
    r.rdata1    = rand_word();
    r.rdata2    = rand_word();
    r.csr_rdata = rand_word();
    r.rd        = rv_isa_pkg::reg_idx_t'(rand_word());
    return r;
  endfunction

  function automatic exec_pkg::exec_req_t rr_req(rv_isa_pkg::alu_op_e op,
                                                 rv_isa_pkg::xlen_t a,
                                                 rv_isa_pkg::xlen_t b);
    exec_pkg::exec_req_t r;
    r        = make_req(rv_isa_pkg::INST_RR, op);
    r.rdata1 = a;
    r.rdata2 = b;
    return r;
  endfunction

  // One clock of the issuer and result sink models, run on the falling edge.
  task automatic next_cycle();
    @(negedge clk_i);
    if (res_valid_o) begin
      results++;
      owed++;
      assert (exp_q.size() != 0) else begin
        err_count++;
        $display("Result for rd %0d in test %s arrived with no op outstanding.",
                 res_o.rd, test_name);
      end
      if (exp_q.size() != 0) begin
        exp_head = exp_q.pop_front();
      end
    end
    res_credit_i = 1'b0;
    if (owed > 0 && !hold_credits && ($random(seed) & 3) == 0) begin
      res_credit_i = 1'b1;
      owed--;
    end
    issue_valid_i = 1'b0;
    if (pend_q.size() != 0 && issue_credits > 0) begin
      issue_req_i   = pend_q.pop_front();
      issue_valid_i = 1'b1;
      exp_q.push_back(expected_result(issue_req_i));
      issue_credits--;
      issued++;
    end
    issue_credits += int'(issue_credit_o);  // Usable from the next cycle on.
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    errs_at_start = err_count;
    ops_at_start  = issued;
  endtask

  task automatic finish_test();
    while (pend_q.size() != 0 || exp_q.size() != 0) begin
      next_cycle();
    end
    repeat (4) next_cycle();
    tests_run++;
    if (err_count != errs_at_start) begin
      tests_failed++;
    end
    $display("test %s: %0d ops, %s", test_name, issued - ops_at_start,
             (err_count == errs_at_start) ? "ok" : "failed");
  endtask

  initial begin
    exec_pkg::exec_req_t    req;
    rv_isa_pkg::inst_type_e itype;
    rv_isa_pkg::xlen_t      shift;
    int                     results_at;
    rst_n_i       = 1'b0;
    issue_valid_i = 1'b0;
    issue_req_i   = '0;
    res_credit_i  = 1'b0;
    hold_credits  = 1'b0;
    exp_head      = '0;
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;
    assert (!res_valid_o && !issue_credit_o) else begin
      err_count++;
      $display("CHECK FAILED reset: expected res_valid 0 issue_credit 0, ",
               "actual res_valid %0b issue_credit %0b", res_valid_o, issue_credit_o);
    end

    start_test("alu");
    repeat (N_ALU) begin
      itype = ($random(seed) & 1) ? rv_isa_pkg::INST_RR : rv_isa_pkg::INST_RI;
      pend_q.push_back(make_req(itype, op_from(rv_isa_pkg::ALU_OP_ADD, 10)));
    end
    finish_test();

    start_test("mul");
    repeat (N_MUL) begin
      pend_q.push_back(make_req(rv_isa_pkg::INST_RR, op_from(rv_isa_pkg::ALU_OP_MUL, 3)));
    end
    finish_test();

    start_test("div");
    pend_q.push_back(rr_req(rv_isa_pkg::ALU_OP_DIV, rand_word(), '0));
    pend_q.push_back(rr_req(rv_isa_pkg::ALU_OP_DIVU, rand_word(), '0));
    pend_q.push_back(rr_req(rv_isa_pkg::ALU_OP_REM, rand_word(), '0));
    pend_q.push_back(rr_req(rv_isa_pkg::ALU_OP_REMU, rand_word(), '0));
    pend_q.push_back(rr_req(rv_isa_pkg::ALU_OP_DIV, 32'h8000_0000, 32'hffff_ffff));
    pend_q.push_back(rr_req(rv_isa_pkg::ALU_OP_REM, 32'h8000_0000, 32'hffff_ffff));
    repeat (N_DIV - 6) begin
      shift = rand_word();
      pend_q.push_back(rr_req(op_from(rv_isa_pkg::ALU_OP_DIV, 4), rand_word(),
                              rand_word() >> shift[4:0]));
    end
    finish_test();

    start_test("operands");
    repeat (N_SEL / 8) begin
      pend_q.push_back(make_req(rv_isa_pkg::INST_LUI, rv_isa_pkg::ALU_OP_LUI));
      pend_q.push_back(make_req(rv_isa_pkg::INST_AUIPC, rv_isa_pkg::ALU_OP_AUIPC));
      pend_q.push_back(make_req(rv_isa_pkg::INST_JAL, rv_isa_pkg::ALU_OP_JUMP));
      pend_q.push_back(make_req(rv_isa_pkg::INST_JALR, rv_isa_pkg::ALU_OP_JUMP));
      pend_q.push_back(make_req(rv_isa_pkg::INST_CSRR, rv_isa_pkg::ALU_OP_CSRR));
      pend_q.push_back(make_req(rv_isa_pkg::INST_NOP, rv_isa_pkg::ALU_OP_ADD));
      pend_q.push_back(make_req(rv_isa_pkg::INST_RR, rv_isa_pkg::ALU_OP_NOP));
      pend_q.push_back(make_req(rv_isa_pkg::INST_CSRR, rv_isa_pkg::ALU_OP_NOP));
    end
    finish_test();

    // Each divide is followed by short ops that must wait behind it.
    start_test("order");
    for (int k = 0; k < N_ORDER; k++) begin
      if (k % 4 == 0) begin
        req = make_req(rv_isa_pkg::INST_RR, op_from(rv_isa_pkg::ALU_OP_DIV, 4));
      end else begin
        req = make_req(rv_isa_pkg::INST_RI, op_from(rv_isa_pkg::ALU_OP_ADD, 10));
      end
      req.rd = rv_isa_pkg::reg_idx_t'(k + 1);
      pend_q.push_back(req);
    end
    finish_test();

    start_test("credits");
    while (owed != 0) begin
      next_cycle();
    end
    next_cycle();
    results_at   = results;
    hold_credits = 1'b1;
    pend_q.push_back(make_req(rv_isa_pkg::INST_RR, rv_isa_pkg::ALU_OP_DIV));
    repeat (N_CREDIT - 1) begin
      pend_q.push_back(make_req(rv_isa_pkg::INST_RI, op_from(rv_isa_pkg::ALU_OP_ADD, 10)));
    end
    repeat (80) next_cycle();
    assert ((results - results_at == RES_CREDITS) && (issue_credits == 0)) else begin
      err_count++;
      $display("CHECK FAILED %s: expected %0d results and 0 issue credits, ", test_name,
               RES_CREDITS, "actual %0d results and %0d issue credits",
               results - results_at, issue_credits);
    end
    hold_credits = 1'b0;
    finish_test();

    assert ((results == issued) && (issued == TOTAL_OPS)) else begin
      err_count++;
      $display("CHECK FAILED op count: expected %0d issued and results, ", TOTAL_OPS,
               "actual %0d issued and %0d results", issued, results);
    end
    $display("%0d tests, %0d failed, %0d results checked, %0d errors",
             tests_run, tests_failed, results, err_count);
    if (err_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
